// ==== hdl/line_adapter_pkg.sv ====
`default_nettype none

package line_adapter_pkg;

    // ------------------------------------------------------------------------
    // Line and beat geometry
    // ------------------------------------------------------------------------

    // Cache line as one word
    localparam int LINE_BITS = 256;

    // Memory beat
    localparam int BEAT_BITS = 64;

    // Beats that make up one line
    localparam int BEATS_PER_LINE = LINE_BITS / BEAT_BITS;

    // Byte offset inside a line that memory addresses clear
    localparam int LINE_OFFSET_BITS = 5;

    // ------------------------------------------------------------------------
    // Line word
    // ------------------------------------------------------------------------

    // Same 256 bits seen flat or as beats
    // Beat 0 sits in bits 63:0 and beat 3 in bits 255:192
    typedef union packed {
        logic [LINE_BITS-1:0]                     flat;
        logic [BEATS_PER_LINE-1:0][BEAT_BITS-1:0] beat;
    } line_t;

endpackage

`default_nettype wire

// ==== hdl/burst_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_assembler (
    input  logic                                 clk,
    input  logic                                 rst,

    // Arm for a new line
    input  logic                                 rd_start,

    // Read beats from memory
    input  logic                                 mem_rvalid,
    input  logic [line_adapter_pkg::BEAT_BITS-1:0] mem_rdata,

    // Completed line
    output logic                                 rd_done,
    output line_adapter_pkg::line_t              rd_line
);
    import line_adapter_pkg::*;

    localparam int CNT_W = $clog2(BEATS_PER_LINE);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BEATS_PER_LINE - 1);

    logic             pending;   // Read issued and beats still due
    logic [CNT_W-1:0] beat_cnt;
    line_t            acc;
    line_t            acc_next;
    logic             take_beat;
    logic             last_beat;

    assign take_beat = pending & mem_rvalid;
    assign last_beat = take_beat & (beat_cnt == LAST_BEAT);

    // Drop the incoming beat into its slot
    always_comb begin
        acc_next = acc;
        acc_next.beat[beat_cnt] = mem_rdata;
    end

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            beat_cnt <= '0;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= last_beat;
            if (rd_start) begin
                pending  <= 1'b1;
                beat_cnt <= '0;
            end else if (take_beat) begin
                beat_cnt <= beat_cnt + 1'b1;  // Wraps to 0 after the last beat
                if (last_beat) begin
                    pending <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Line data
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (take_beat) begin
            acc <= acc_next;
        end
        if (last_beat) begin
            rd_line <= acc_next;  // Complete line including beat 3
        end
    end

endmodule

`default_nettype wire

// ==== hdl/burst_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_serializer (
    input  logic                                 clk,
    input  logic                                 rst,

    // Line to send
    input  logic                                 wr_start,
    input  line_adapter_pkg::line_t              wr_line,

    // Beat stream towards memory
    output logic                                 beat_valid,
    output logic [line_adapter_pkg::BEAT_BITS-1:0] beat_data,
    input  logic                                 beat_ready,

    // All beats taken
    output logic                                 wr_done
);
    import line_adapter_pkg::*;

    localparam int CNT_W = $clog2(BEATS_PER_LINE);
    localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(BEATS_PER_LINE - 1);

    line_t            line_q;
    logic [CNT_W-1:0] beat_idx;
    logic             beat_taken;
    logic             last_taken;

    assign beat_taken = beat_valid & beat_ready;
    assign last_taken = beat_taken & (beat_idx == LAST_BEAT);

    // Current beat held until taken
    assign beat_data = line_q.beat[beat_idx];

    // ------------------------------------------------------------------------
    // Beat sequencing
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_valid <= 1'b0;
            beat_idx   <= '0;
            wr_done    <= 1'b0;
        end else begin
            wr_done <= last_taken;
            if (wr_start) begin
                beat_valid <= 1'b1;
                beat_idx   <= '0;
            end else if (beat_taken) begin
                if (last_taken) begin
                    beat_valid <= 1'b0;
                    beat_idx   <= '0;
                end else begin
                    beat_idx <= beat_idx + 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Line capture
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (wr_start) begin
            line_q <= wr_line;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/line_resp_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_resp_merge #(
    parameter int ADDR_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // Cache side
    input  logic                                 req_valid,
    input  logic                                 req_write,
    input  logic [ADDR_W-1:0]                    req_addr,
    input  line_adapter_pkg::line_t              req_wdata,
    output logic                                 req_ready,
    output logic                                 resp_valid,
    output line_adapter_pkg::line_t              resp_rdata,

    // Read path
    output logic                                 rd_start,
    input  logic                                 rd_done,
    input  line_adapter_pkg::line_t              rd_line,

    // Write path
    output logic                                 wr_start,
    output line_adapter_pkg::line_t              wr_line,
    input  logic                                 beat_valid,
    input  logic [line_adapter_pkg::BEAT_BITS-1:0] beat_data,
    output logic                                 beat_ready,
    input  logic                                 wr_done,

    // Memory side
    input  logic                                 mem_ready,
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [ADDR_W-1:0]                    mem_addr,
    output logic [line_adapter_pkg::BEAT_BITS-1:0] mem_wdata
);
    import line_adapter_pkg::*;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_READ  = 2'd1;
    localparam logic [1:0] ST_WRITE = 2'd2;

    logic [1:0]        state;
    logic              rd_cmd;   // Read command waiting for memory
    logic [ADDR_W-1:0] addr_q;
    logic              accept;
    logic              done;

    assign done      = rd_done | wr_done;
    assign req_ready = (state == ST_IDLE) | done;  // Free again in the response cycle
    assign accept    = req_valid & req_ready;

    assign rd_start = accept & ~req_write;
    assign wr_start = accept & req_write;
    assign wr_line  = req_wdata;  // Serializer grabs it on the accepting edge

    // ------------------------------------------------------------------------
    // Request tracking
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            rd_cmd <= 1'b0;
        end else begin
            if (accept) begin
                state <= req_write ? ST_WRITE : ST_READ;
            end else if (done) begin
                state <= ST_IDLE;
            end
            if (rd_start) begin
                rd_cmd <= 1'b1;
            end else if (rd_cmd && mem_ready) begin
                rd_cmd <= 1'b0;
            end
        end
    end

    // Line aligned address
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= {req_addr[ADDR_W-1:LINE_OFFSET_BITS], {LINE_OFFSET_BITS{1'b0}}};
        end
    end

    // ------------------------------------------------------------------------
    // Memory steering and response
    // ------------------------------------------------------------------------

    assign mem_read   = rd_cmd;
    assign mem_addr   = addr_q;
    assign mem_write  = (state == ST_WRITE) & beat_valid;
    assign mem_wdata  = beat_data;
    assign beat_ready = (state == ST_WRITE) & mem_ready;

    assign resp_valid = done;     // Both done pulses come straight from flops
    assign resp_rdata = rd_line;  // Don't care on writes

endmodule

`default_nettype wire

// ==== hdl/line_adapter.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_adapter #(
    parameter int ADDR_W = 32
) (
    input  logic                                 clk,
    input  logic                                 rst,

    // Cache side
    input  logic                                 req_valid,
    output logic                                 req_ready,
    input  logic                                 req_write,
    input  logic [ADDR_W-1:0]                    req_addr,
    input  line_adapter_pkg::line_t              req_wdata,
    output logic                                 resp_valid,
    output line_adapter_pkg::line_t              resp_rdata,

    // Burst memory side
    output logic                                 mem_read,
    output logic                                 mem_write,
    output logic [ADDR_W-1:0]                    mem_addr,
    output logic [line_adapter_pkg::BEAT_BITS-1:0] mem_wdata,
    input  logic                                 mem_ready,
    input  logic                                 mem_rvalid,
    input  logic [line_adapter_pkg::BEAT_BITS-1:0] mem_rdata
);
    import line_adapter_pkg::*;

    logic                 rd_start;
    logic                 rd_done;
    line_t                rd_line;
    logic                 wr_start;
    line_t                wr_line;
    logic                 beat_valid;
    logic                 beat_ready;
    logic [BEAT_BITS-1:0] beat_data;
    logic                 wr_done;

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------

    burst_assembler i_assembler (
        .clk        (clk),
        .rst        (rst),
        .rd_start   (rd_start),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .rd_done    (rd_done),
        .rd_line    (rd_line)
    );

    // ------------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------------

    burst_serializer i_serializer (
        .clk        (clk),
        .rst        (rst),
        .wr_start   (wr_start),
        .wr_line    (wr_line),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_ready (beat_ready),
        .wr_done    (wr_done)
    );

    // ------------------------------------------------------------------------
    // Control and response
    // ------------------------------------------------------------------------

    line_resp_merge #(
        .ADDR_W (ADDR_W)
    ) i_merge (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .rd_start   (rd_start),
        .rd_done    (rd_done),
        .rd_line    (rd_line),
        .wr_start   (wr_start),
        .wr_line    (wr_line),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_ready (beat_ready),
        .wr_done    (wr_done),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== tests/line_adapter_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_adapter_sva #(
    parameter int ADDR_W = 32
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   req_valid,
    input  logic                                   req_ready,
    input  logic                                   resp_valid,
    input  logic                                   mem_read,
    input  logic                                   mem_write,
    input  logic                                   mem_ready,
    input  logic [ADDR_W-1:0]                      mem_addr,
    input  logic [line_adapter_pkg::BEAT_BITS-1:0] mem_wdata
);
    int unsigned err_count = 0;
    logic        busy;

    // Request in flight until its response
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (req_valid && req_ready) begin
            busy <= 1'b1;
        end else if (resp_valid) begin
            busy <= 1'b0;
        end
    end

    a_busy_blocks : assert property (@(posedge clk) disable iff (rst)
        busy && !resp_valid |-> !req_ready)
        else begin
            err_count++;
            $error("req_ready high while busy");
        end

    a_beat_held : assert property (@(posedge clk) disable iff (rst)
        mem_write && !mem_ready |=> mem_write && $stable(mem_addr) && $stable(mem_wdata))
        else begin
            err_count++;
            $error("Write beat changed under back-pressure");
        end

    a_one_cmd : assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else begin
            err_count++;
            $error("mem_read and mem_write high together");
        end

    a_resp_pulse : assert property (@(posedge clk) disable iff (rst)
        resp_valid |=> !resp_valid)
        else begin
            err_count++;
            $error("resp_valid longer than one cycle");
        end

endmodule

`default_nettype wire

// ==== tests/line_adapter_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_adapter_tb;
    import line_adapter_pkg::*;

    localparam int          ADDR_W     = 32;
    localparam int          CLK_PERIOD = 20;
    localparam int          RST_CYCLES = 5;
    localparam int          NUM_REQS   = 60;
    localparam int          POOL       = 8;    // Distinct lines in use
    localparam int          MAX_GAP    = 3;    // Longest random stall
    localparam int          IDLE_MAX   = 3;    // Cache idle cycles between requests
    localparam int unsigned SEED       = 32'h28fe_00ad;
    localparam logic [ADDR_W-1:0] BASE_ADDR = 32'h0001_0000;

    // Worst case per request covers idle, command wait, four stalled beats and response
    localparam int REQ_CYCLES  = IDLE_MAX + (BEATS_PER_LINE + 1) * (MAX_GAP + 1) + 8;
    localparam int WATCHDOG_NS = (RST_CYCLES + NUM_REQS * REQ_CYCLES) * CLK_PERIOD;

    logic                 clk        = 1'b0;
    logic                 rst;
    logic                 req_valid;
    logic                 req_ready;
    logic                 req_write;
    logic [ADDR_W-1:0]    req_addr;
    line_t                req_wdata;
    logic                 resp_valid;
    line_t                resp_rdata;
    logic                 mem_read;
    logic                 mem_write;
    logic [ADDR_W-1:0]    mem_addr;
    logic [BEAT_BITS-1:0] mem_wdata;
    logic                 mem_ready  = 1'b0;
    logic                 mem_rvalid = 1'b0;
    logic [BEAT_BITS-1:0] mem_rdata  = '0;

    // Memory model and scoreboard state
    line_t             mem_lines [logic [ADDR_W-1:0]];
    line_t             expected  [logic [ADDR_W-1:0]];
    line_t             wr_buf;
    line_t             cur_line;
    logic [ADDR_W-1:0] cur_addr;
    logic [ADDR_W-1:0] rd_addr;
    bit                cur_write;
    bit                busy;
    int                wr_beats;
    int                rd_left;
    int                rd_idx;
    int                rd_gap;
    int                ready_wait;
    int                accept_count;
    int                resp_count;

    always #(CLK_PERIOD / 2) clk = ~clk;

    line_adapter #(
        .ADDR_W (ADDR_W)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .resp_valid (resp_valid),
        .resp_rdata (resp_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata)
    );

    bind line_adapter line_adapter_sva #(.ADDR_W(ADDR_W)) i_sva (
        .clk        (clk),
        .rst        (rst),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_ready  (mem_ready),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    function automatic string mismatch_text(input string name, input logic [255:0] got,
                                            input logic [255:0] exp);
        return $sformatf("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    endfunction

    // ------------------------------------------------------------------------
    // Command and response timing
    // ------------------------------------------------------------------------

    a_read_cmd : assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && !req_write |=> mem_read)
        else fail_now("mem_read did not rise after a read was accepted");

    a_write_beat : assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready && req_write |=> mem_write)
        else fail_now("mem_write did not rise after a write was accepted");

    a_read_held : assert property (@(posedge clk) disable iff (rst)
        mem_read && !mem_ready |=> mem_read)
        else fail_now("mem_read dropped before memory took it");

    a_read_resp : assert property (@(posedge clk) disable iff (rst)
        mem_rvalid && rd_left == 0 |=> resp_valid)
        else fail_now("resp_valid missing in the cycle after the last read beat");

    a_write_resp : assert property (@(posedge clk) disable iff (rst)
        mem_write && mem_ready && wr_beats == BEATS_PER_LINE - 1 |=> resp_valid)
        else fail_now("resp_valid missing in the cycle after the last write beat");

    a_ready_on_resp : assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> req_ready)
        else fail_now("req_ready low in the response cycle");

    // ------------------------------------------------------------------------
    // Memory model
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst && mem_read && mem_ready) begin
            assert (mem_addr == cur_addr)
                else fail_now(mismatch_text("mem_addr", mem_addr, cur_addr));
            rd_addr = mem_addr;
            rd_left = BEATS_PER_LINE;
            rd_idx  = 0;
            rd_gap  = $urandom_range(0, MAX_GAP);
        end
        if (!rst && mem_write && mem_ready) begin
            assert (mem_addr == cur_addr)
                else fail_now(mismatch_text("mem_addr", mem_addr, cur_addr));
            assert (wr_beats < BEATS_PER_LINE)
                else fail_now("More than four write beats for a line");
            assert (mem_wdata == cur_line.beat[wr_beats])
                else fail_now(mismatch_text("mem_wdata", mem_wdata, cur_line.beat[wr_beats]));
            wr_buf.beat[wr_beats] = mem_wdata;
            wr_beats++;
            if (wr_beats == BEATS_PER_LINE) begin
                mem_lines[mem_addr] = wr_buf;
            end
        end
    end

    // Ready stalls and read beats with random gaps
    always @(negedge clk) begin
        mem_ready = (ready_wait == 0);
        ready_wait = (ready_wait == 0) ? $urandom_range(0, MAX_GAP) : ready_wait - 1;
        mem_rvalid = (rd_left != 0) && (rd_gap == 0);
        if (mem_rvalid) begin
            mem_rdata = mem_lines[rd_addr].beat[rd_idx];
            rd_idx++;
            rd_left--;
            rd_gap = $urandom_range(0, MAX_GAP);
        end else if (rd_gap != 0) begin
            rd_gap--;
        end
    end

    // ------------------------------------------------------------------------
    // Scoreboard
    // ------------------------------------------------------------------------

    always @(posedge clk) begin
        if (!rst) begin
            if (busy && !resp_valid) begin
                assert (!req_ready) else fail_now("req_ready high while a request is busy");
            end
            if (resp_valid) begin
                assert (busy) else fail_now("Response without an outstanding request");
                if (cur_write) begin
                    assert (wr_beats == BEATS_PER_LINE)
                        else fail_now(mismatch_text("write beat count", wr_beats, BEATS_PER_LINE));
                    assert (mem_lines[cur_addr] == expected[cur_addr])
                        else fail_now(mismatch_text("stored line", mem_lines[cur_addr],
                                                    expected[cur_addr]));
                end else begin
                    assert (resp_rdata == cur_line)
                        else fail_now(mismatch_text("resp_rdata", resp_rdata, cur_line));
                end
                busy = 1'b0;
                resp_count++;
            end
            if (req_valid && req_ready) begin
                assert (!busy) else fail_now("Request accepted while the previous one was busy");
                cur_write = req_write;
                cur_addr  = (req_addr >> LINE_OFFSET_BITS) << LINE_OFFSET_BITS;
                if (req_write) begin
                    expected[cur_addr] = req_wdata;
                    wr_beats = 0;
                end
                assert (expected.exists(cur_addr)) else fail_now("Read of a line never written");
                cur_line = expected[cur_addr];
                busy = 1'b1;
                accept_count++;
            end
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_sva.err_count != 0) begin
            fail_now("Protocol assertion failed in the bound checker");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("Watchdog expired before all responses arrived");
    end

    // ------------------------------------------------------------------------
    // Cache side stimulus
    // ------------------------------------------------------------------------

    initial begin
        int unsigned pick;
        int unsigned idle;
        bit          accepted;
        bit          written [POOL];
        line_t       wdata;
        void'($urandom(SEED));
        busy         = 1'b0;
        accept_count = 0;
        resp_count   = 0;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        assert (req_ready && !resp_valid && !mem_read && !mem_write)
            else fail_now("Outputs not idle after reset");
        for (int n = 0; n < NUM_REQS; n++) begin
            pick = $urandom_range(0, POOL - 1);
            for (int w = 0; w < LINE_BITS / 32; w++) begin
                wdata.flat[32*w +: 32] = $urandom;
            end
            req_valid = 1'b1;
            req_write = !written[pick] || ($urandom_range(0, 1) == 1);
            req_addr  = BASE_ADDR + (pick << LINE_OFFSET_BITS) + $urandom_range(0, 31);
            req_wdata = wdata;
            written[pick] = written[pick] | req_write;
            accepted = 1'b0;
            while (!accepted) begin
                accepted = req_ready;  // Value the next rising edge sees
                @(negedge clk);
            end
            idle = $urandom_range(0, IDLE_MAX);
            if (idle != 0) begin
                req_valid = 1'b0;
                repeat (idle) @(negedge clk);
            end
        end
        req_valid = 1'b0;
        wait (resp_count == NUM_REQS);
        @(negedge clk);
        if (accept_count == NUM_REQS && resp_count == NUM_REQS
                && i_dut.i_sva.err_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            fail_now("Request and response counts differ at the end of the run");
        end
    end

endmodule

`default_nettype wire

// ==== flist.f ====
hdl/line_adapter_pkg.sv
hdl/burst_assembler.sv
hdl/burst_serializer.sv
hdl/line_resp_merge.sv
hdl/line_adapter.sv
tests/line_adapter_sva.sv
tests/line_adapter_tb.sv

// ==== Bender.yml ====
package:
  name: line_adapter

sources:
  - hdl/line_adapter_pkg.sv
  - hdl/burst_assembler.sv
  - hdl/burst_serializer.sv
  - hdl/line_resp_merge.sv
  - hdl/line_adapter.sv
  - target: test
    files:
      - tests/line_adapter_sva.sv
      - tests/line_adapter_tb.sv
